// File: project.f
src/fetch_pkg.sv
src/pc_gen.sv
src/fetch.sv
src/instr_decode.sv
src/prog_mem.sv
src/fetch_top.sv
sim/tb_fetch_top.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing -j 0
TOP       := tb_fetch_top
FILELIST  := project.f
OBJ_DIR   := obj_dir
LOG       := sim.log

SOURCES := $(shell grep '\.sv$$' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run check clean

all: check

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)

check: run
	@grep -q '^STATUS: PASS$$' $(LOG) || { echo "pass message missing from $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: sim/tb_fetch_top.sv
`timescale 1ns/1ps

module tb_fetch_top import fetch_pkg::*; ();

    localparam int MEM_AW      = 10;
    localparam int MAX_LAT     = 3;
    localparam int MEM_WORDS   = 2 ** MEM_AW;
    localparam int N_RETIRE    = 600;
    // per retire budget, then reset, boot load and a small margin
    localparam int CYCLE_LIMIT = N_RETIRE * (MAX_LAT + 8) + MEM_WORDS + 3 + 16;

    logic              clk = 1'b0;
    logic              rst;
    logic              boot;
    logic              irq_in;
    logic              irq_en;
    logic              load_we;
    logic [MEM_AW-1:0] load_addr;
    instr_t            load_data;
    logic              retire_valid;
    pc_t               retire_pc;
    page_t             retire_page;
    instr_t            retire_instr;
    logic              irq_pending;

    instr_t      prog [MEM_WORDS];  // program image shared with the model
    logic [31:0] rng_state = 32'd84336;
    int          cycles    = 0;
    int          n_retired = 0;

    pc_t    m_pc;        // model of the architectural pc
    page_t  m_page;
    instr_t m_word;
    logic   m_pending;
    logic   m_irq_prev;
    logic   m_at_vec;
    logic   m_rise;

    fetch_top #(.MEM_AW(MEM_AW), .MAX_LAT(MAX_LAT)) dut (
        .clk          (clk),
        .rst          (rst),
        .boot         (boot),
        .irq_in       (irq_in),
        .irq_en       (irq_en),
        .load_we      (load_we),
        .load_addr    (load_addr),
        .load_data    (load_data),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .retire_page  (retire_page),
        .retire_instr (retire_instr),
        .irq_pending  (irq_pending)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] xorshift32();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic logic [MEM_AW-1:0] mem_index(page_t pg, pc_t p);
        logic [23:0] full;
        full = {pg, p};
        return full[MEM_AW-1:0];
    endfunction

    function automatic instr_t ordinary_word(logic [31:0] r);
        opcode_t op;
        op = r[6:0];
        if (op inside {OP_LOAD, OP_STORE, OP_JUMP, OP_PUSH, OP_POP}) begin
            op = op | 7'h40;  // out of the special opcodes
        end
        return {r[31:7], op};
    endfunction

    function automatic instr_t mem_op_word(logic [31:0] r);
        opcode_t op;
        case (r[1:0])
            2'd0:    op = OP_LOAD;
            2'd1:    op = OP_STORE;
            2'd2:    op = OP_PUSH;
            default: op = OP_POP;
        endcase
        return {r[31:7], op};
    endfunction

    function automatic instr_t jump_word(logic [31:0] r);
        pc_t target;
        target = pc_t'(r[MEM_AW-1:0]);  // always inside the memory
        return {target, r[23:16], 1'b0, OP_JUMP};
    endfunction

    task automatic build_program();
        logic [31:0] r;
        int          run_left;
        run_left = 0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            r = xorshift32();
            if (run_left > 0) begin
                prog[i] = mem_op_word(r);
                run_left = run_left - 1;
            end else if (r[11:8] == 4'd0) begin
                prog[i] = jump_word(xorshift32());
            end else if (r[11:8] == 4'd1) begin
                prog[i] = mem_op_word(r);
                run_left = 1 + int'(r[14:12]);  // run of 2 to 9
            end else begin
                prog[i] = ordinary_word(r);
            end
        end
        // vector entry must fall through
        prog[mem_index(IRQ_VECTOR_PAGE, IRQ_VECTOR_PC)] = ordinary_word(xorshift32());
    endtask

    task automatic expect_equal(string name, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            $display("error at %0d ns: %s is %h, expected %h", $time, name, got, exp);
            $display("STATUS: FAIL");
            $fatal(1, "%s mismatch", name);
        end
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, %0d of %0d instructions retired",
                     cycles, n_retired, N_RETIRE);
            $display("STATUS: FAIL");
            $fatal(1, "run did not complete");
        end
    end

    // reference model of the retire stream and the pending flag
    always @(posedge clk) begin
        if (rst) begin
            m_pc       = '0;
            m_page     = '0;
            m_pending  = 1'b0;
            m_irq_prev = 1'b0;
        end else begin
            m_at_vec = 1'b0;
            expect_equal("irq_pending", 32'(irq_pending), 32'(m_pending));
            if (boot) begin
                expect_equal("retire_valid", 32'(retire_valid), 32'd0);
                m_pc   = '0;
                m_page = '0;
            end else if (retire_valid) begin
                m_word = prog[mem_index(m_page, m_pc)];
                expect_equal("retire_pc", 32'(retire_pc), 32'(m_pc));
                expect_equal("retire_page", 32'(retire_page), 32'(m_page));
                expect_equal("retire_instr", retire_instr, m_word);
                m_at_vec = m_pc == IRQ_VECTOR_PC && m_page == IRQ_VECTOR_PAGE;
                if (m_word[6:0] == OP_JUMP) begin
                    m_pc   = m_word[31:16];
                    m_page = m_word[15:8];
                end else if (m_pending && !m_at_vec) begin
                    m_pc   = IRQ_VECTOR_PC;
                    m_page = IRQ_VECTOR_PAGE;
                end else begin
                    m_pc = m_pc + 16'd1;
                end
                n_retired <= n_retired + 1;
            end
            m_rise = irq_in && !m_irq_prev && irq_en;
            if (m_rise) begin
                m_pending = 1'b1;
            end else if (m_at_vec) begin
                m_pending = 1'b0;  // vector has retired
            end
            m_irq_prev = irq_in;
        end
    end

    initial begin : stimulus
        logic [31:0] r;
        rst       = 1'b1;
        boot      = 1'b1;
        irq_in    = 1'b0;
        irq_en    = 1'b0;
        load_we   = 1'b0;
        load_addr = '0;
        load_data = '0;
        build_program();
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            @(posedge clk);
            load_we   <= 1'b1;
            load_addr <= MEM_AW'(i);
            load_data <= prog[i];
        end
        @(posedge clk);
        load_we <= 1'b0;
        repeat (4) @(posedge clk);  // boot still high so nothing may retire
        boot   <= 1'b0;
        irq_en <= 1'b1;
        while (n_retired < N_RETIRE) begin
            @(posedge clk);
            r = xorshift32();
            if (r[5:0] == 6'd0) begin
                irq_in <= !irq_in;
            end
            if (r[15:10] == 6'd0) begin
                irq_en <= r[16] | r[17];  // mostly enabled
            end
        end
        $display("%0d instructions retired in %0d cycles", n_retired, cycles);
        $display("STATUS: PASS");
        $finish;
    end

endmodule

// File: src/fetch_top.sv
`timescale 1ns/1ps

module fetch_top import fetch_pkg::*; #(
    parameter int MEM_AW  = 10,
    parameter int MAX_LAT = 3
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              boot,
    input  logic              irq_in,
    input  logic              irq_en,
    input  logic              load_we,
    input  logic [MEM_AW-1:0] load_addr,
    input  instr_t            load_data,
    output logic              retire_valid,
    output pc_t               retire_pc,
    output page_t             retire_page,
    output instr_t            retire_instr,
    output logic              irq_pending
);

    pc_t               pc;
    page_t             page;
    instr_t            instr;
    logic              instr_valid;
    logic              jump_taken;
    pc_t               jump_pc;
    page_t             jump_page;
    logic              mem_read;
    logic [MEM_AW-1:0] mem_addr;
    logic              mem_busy;
    logic              mem_cack;
    instr_t            mem_data;
    logic              mem_data_ready;

    assign retire_page = page;  // page moves only after the retire

    pc_gen u_pc_gen (
        .clk          (clk),
        .rst          (rst),
        .boot         (boot),
        .irq_in       (irq_in),
        .irq_en       (irq_en),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .jump_taken   (jump_taken),
        .jump_pc      (jump_pc),
        .jump_page    (jump_page),
        .pc           (pc),
        .page         (page),
        .irq_pending  (irq_pending)
    );

    fetch #(.MEM_AW(MEM_AW)) u_fetch (
        .clk            (clk),
        .rst            (rst),
        .boot           (boot),
        .pc             (pc),
        .page           (page),
        .mem_busy       (mem_busy),
        .mem_cack       (mem_cack),
        .mem_data       (mem_data),
        .mem_data_ready (mem_data_ready),
        .mem_read       (mem_read),
        .mem_addr       (mem_addr),
        .instr          (instr),
        .instr_valid    (instr_valid),
        .pc_hold        ()
    );

    instr_decode u_decode (
        .clk          (clk),
        .rst          (rst),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .pc           (pc),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .retire_instr (retire_instr),
        .jump_taken   (jump_taken),
        .jump_pc      (jump_pc),
        .jump_page    (jump_page)
    );

    prog_mem #(.MEM_AW(MEM_AW), .MAX_LAT(MAX_LAT)) u_prog_mem (
        .clk            (clk),
        .rst            (rst),
        .boot           (boot),
        .mem_read       (mem_read),
        .mem_addr       (mem_addr),
        .load_we        (load_we),
        .load_addr      (load_addr),
        .load_data      (load_data),
        .mem_busy       (mem_busy),
        .mem_cack       (mem_cack),
        .mem_data       (mem_data),
        .mem_data_ready (mem_data_ready)
    );

endmodule

// File: src/prog_mem.sv
`timescale 1ns/1ps

module prog_mem import fetch_pkg::*; #(
    parameter int MEM_AW  = 10,
    parameter int MAX_LAT = 3
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              boot,
    input  logic              mem_read,
    input  logic [MEM_AW-1:0] mem_addr,
    input  logic              load_we,
    input  logic [MEM_AW-1:0] load_addr,
    input  instr_t            load_data,
    output logic              mem_busy,
    output logic              mem_cack,
    output instr_t            mem_data,
    output logic              mem_data_ready
);

    localparam int CW = $clog2(MAX_LAT + 1);

    instr_t mem [2**MEM_AW];

    logic [7:0]    lfsr;
    logic [CW-1:0] lat;
    logic [CW-1:0] wait_cnt;

    assign lat = CW'(lfsr % MAX_LAT) + CW'(1);  // 1 .. MAX_LAT

    assign mem_cack       = mem_read && !mem_busy;
    assign mem_data_ready = mem_busy && wait_cnt == CW'(1);

    always_ff @(posedge clk) begin
        if (rst) begin
            mem_busy <= 1'b0;
            wait_cnt <= '0;
            lfsr     <= 8'h5a;
        end else if (mem_cack) begin
            mem_busy <= 1'b1;
            wait_cnt <= lat;
            lfsr     <= {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
        end else if (mem_busy) begin
            if (mem_data_ready) begin
                mem_busy <= 1'b0;  // free again next cycle
            end
            wait_cnt <= wait_cnt - CW'(1);
        end
    end

    // load port only during boot
    always_ff @(posedge clk) begin
        if (boot && load_we) begin
            mem[load_addr] <= load_data;
        end
        if (mem_cack) begin
            mem_data <= mem[mem_addr];
        end
    end

endmodule

// File: src/instr_decode.sv
`timescale 1ns/1ps

module instr_decode import fetch_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   instr_valid,
    input  instr_t instr,
    input  pc_t    pc,
    output logic   retire_valid,
    output pc_t    retire_pc,
    output instr_t retire_instr,
    output logic   jump_taken,
    output pc_t    jump_pc,
    output page_t  jump_page
);

    opcode_t opcode;
    logic    is_jump;

    assign opcode  = instr[6:0];
    assign is_jump = opcode == OP_JUMP;

    always_ff @(posedge clk) begin
        if (rst) begin
            retire_valid <= 1'b0;
            jump_taken   <= 1'b0;
        end else begin
            retire_valid <= instr_valid;
            jump_taken   <= instr_valid && is_jump;
        end
    end

    always_ff @(posedge clk) begin
        if (instr_valid) begin
            retire_pc    <= pc;  // pc is still the fetched one here
            retire_instr <= instr;
            jump_pc      <= instr[31:16];
            jump_page    <= instr[15:8];
        end
    end

endmodule

// File: src/fetch.sv
`timescale 1ns/1ps

module fetch import fetch_pkg::*; #(
    parameter int MEM_AW = 10
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              boot,
    input  pc_t               pc,
    input  page_t             page,
    input  logic              mem_busy,
    input  logic              mem_cack,
    input  instr_t            mem_data,
    input  logic              mem_data_ready,
    output logic              mem_read,
    output logic [MEM_AW-1:0] mem_addr,
    output instr_t            instr,
    output logic              instr_valid,
    output logic              pc_hold
);

    fetch_state_e state;
    fetch_state_e state_n;

    pc_t         prev_pc;
    page_t       prev_page;
    logic [1:0]  step_dly;  // follows instr_valid to the pc update
    pc_t         pf_pc;
    page_t       pf_page;
    instr_t      pf_data;
    instr_t      instr_q;
    logic [23:0] cur_full;
    logic [23:0] next_full;

    logic   new_pc;
    logic   want;
    logic   pf_hit;
    logic   deliver;
    instr_t dlv_data;
    logic   issue_demand;
    logic   issue_pf;

    // a jump to itself keeps the pc value, so the retire timing is watched as well
    assign new_pc = pc != prev_pc || page != prev_page || step_dly[1];
    assign want   = new_pc || pc_hold;  // current pc still has no instruction
    assign pf_hit = pc == pf_pc && page == pf_page;

    assign cur_full  = {page, pc};
    assign next_full = {page, pc + pc_t'(1)};

    assign instr = pc_hold ? instr_t'(OP_NOP) : instr_q;

    always_comb begin
        state_n      = state;
        deliver      = 1'b0;
        dlv_data     = mem_data;
        issue_demand = 1'b0;
        issue_pf     = 1'b0;
        case (state)
            S_IDLE: begin
                if (want && !mem_busy) begin
                    issue_demand = 1'b1;
                end
            end
            S_READ: begin
                if (mem_data_ready) begin
                    deliver = 1'b1;
                end
            end
            S_PREFETCH: begin
                if (mem_data_ready) begin
                    if (!want) begin
                        state_n = S_PF_HELD;  // keep it until the pc moves
                    end else if (pf_hit) begin
                        deliver = 1'b1;
                    end else begin
                        issue_demand = 1'b1;
                    end
                end
            end
            S_PF_HELD: begin
                dlv_data = pf_data;
                if (want) begin
                    if (pf_hit) begin
                        deliver = 1'b1;
                    end else begin
                        issue_demand = 1'b1;  // miss, drop the held word
                    end
                end
            end
            default: state_n = S_IDLE;
        endcase

        if (deliver) begin
            if (is_mem_op(dlv_data[6:0])) begin
                state_n = S_IDLE;
            end else begin
                issue_pf = 1'b1;  // static prediction pc+1
            end
        end
        if (issue_demand) begin
            state_n = S_READ;
        end
        if (issue_pf) begin
            state_n = S_PREFETCH;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || boot) begin
            state       <= S_IDLE;
            mem_read    <= 1'b0;
            instr_valid <= 1'b0;
            pc_hold     <= 1'b0;
            step_dly    <= '0;
            prev_pc     <= '1;  // forces a demand read once boot ends
            prev_page   <= '0;
        end else begin
            state       <= state_n;
            instr_valid <= deliver;
            step_dly    <= {step_dly[0], instr_valid};
            prev_pc     <= pc;
            prev_page   <= page;
            if (issue_demand || issue_pf) begin
                mem_read <= 1'b1;
            end else if (mem_cack) begin
                mem_read <= 1'b0;
            end
            if (deliver) begin
                pc_hold <= 1'b0;
            end else if (new_pc) begin
                pc_hold <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (deliver) begin
            instr_q <= dlv_data;
        end
        if (issue_demand) begin
            mem_addr <= cur_full[MEM_AW-1:0];
        end
        if (issue_pf) begin
            mem_addr <= next_full[MEM_AW-1:0];
            pf_pc    <= pc + pc_t'(1);
            pf_page  <= page;
        end
        if (state == S_PREFETCH && mem_data_ready) begin
            pf_data <= mem_data;
        end
    end

endmodule

// File: src/pc_gen.sv
`timescale 1ns/1ps

module pc_gen import fetch_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  boot,
    input  logic  irq_in,
    input  logic  irq_en,
    input  logic  retire_valid,
    input  pc_t   retire_pc,
    input  logic  jump_taken,
    input  pc_t   jump_pc,
    input  page_t jump_page,
    output pc_t   pc,
    output page_t page,
    output logic  irq_pending
);

    logic irq_prev;
    logic irq_rise;
    logic at_vector;

    assign irq_rise = irq_in && !irq_prev && irq_en;
    // page has not moved yet while the instruction retires
    assign at_vector = retire_valid && retire_pc == IRQ_VECTOR_PC && page == IRQ_VECTOR_PAGE;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc          <= '0;
            page        <= '0;
            irq_prev    <= 1'b0;
            irq_pending <= 1'b0;
        end else begin
            irq_prev <= irq_in;
            if (irq_rise) begin
                irq_pending <= 1'b1;
            end else if (at_vector) begin
                irq_pending <= 1'b0;  // handler entered
            end

            if (boot) begin
                pc   <= '0;
                page <= '0;
            end else if (retire_valid) begin
                if (jump_taken) begin
                    pc   <= jump_pc;
                    page <= jump_page;
                end else if (irq_pending && !at_vector) begin
                    pc   <= IRQ_VECTOR_PC;
                    page <= IRQ_VECTOR_PAGE;
                end else begin
                    pc <= pc + pc_t'(1);  // sequential, page unchanged
                end
            end
        end
    end

endmodule

// File: src/fetch_pkg.sv
package fetch_pkg;

    typedef logic [15:0] pc_t;
    typedef logic [7:0]  page_t;
    typedef logic [31:0] instr_t;
    typedef logic [6:0]  opcode_t;

    localparam opcode_t OP_NOP   = 7'd0;  // hold instruction, whole word zero
    localparam opcode_t OP_LOAD  = 7'd2;
    localparam opcode_t OP_STORE = 7'd3;
    localparam opcode_t OP_JUMP  = 7'd4;  // page in [15:8], target pc in [31:16]
    localparam opcode_t OP_PUSH  = 7'd5;
    localparam opcode_t OP_POP   = 7'd6;

    localparam pc_t   IRQ_VECTOR_PC   = 16'd1;
    localparam page_t IRQ_VECTOR_PAGE = 8'd0;

    typedef enum logic [1:0] {
        S_IDLE,
        S_READ,
        S_PREFETCH,
        S_PF_HELD
    } fetch_state_e;

    // opcodes that touch data memory, no prefetch behind them
    function automatic logic is_mem_op(opcode_t op);
        return op == OP_LOAD || op == OP_STORE || op == OP_PUSH || op == OP_POP;
    endfunction

endpackage
